// ==== rtl/ocl_pkg.sv ====
package ocl_pkg;

  // --------------------------------------------------
  // Management bus geometry
  // --------------------------------------------------

  // AXI-Lite address and data widths
  localparam int unsigned ocl_addr_w = 32;
  localparam int unsigned ocl_data_w = 32;

  // One strobe bit per data byte
  localparam int unsigned ocl_strb_w = ocl_data_w / 8;

  // Only OKAY is ever returned
  localparam logic [1:0] ocl_resp_okay = 2'b00;

  // Read data for addresses no block owns
  localparam logic [ocl_data_w-1:0] unimpl_reg_value = 32'hdead_beef;

  // --------------------------------------------------
  // Board register map
  // --------------------------------------------------

  // Scratch register, reads back byte-swapped
  localparam logic [31:0] hello_world_addr = 32'h0000_0500;

  // Virtual LED shadow, read-only
  localparam logic [31:0] vled_addr = 32'h0000_0504;

  // Virtual LED and DIP switch count
  localparam int unsigned vled_w = 16;

endpackage

// ==== rtl/miner_pkg.sv ====
package miner_pkg;

  // --------------------------------------------------
  // Hashing core geometry
  // --------------------------------------------------

  // Parallel hash blocks in the core
  localparam int unsigned blk_cnt = 8;

  // Select width for one of the hash blocks
  localparam int unsigned hash_sel_w = $clog2(blk_cnt);

  // Core status code width
  localparam int unsigned status_w = 2;

  // --------------------------------------------------
  // Miner register map
  // --------------------------------------------------

  // Write side, strobed loads
  localparam logic [31:0] blockheader_addr = 32'h0000_0010;
  localparam logic [31:0] matrix_addr      = 32'h0000_0014;
  localparam logic [31:0] target_addr      = 32'h0000_0018;

  // Write side, held settings and commands
  localparam logic [31:0] noncesize_addr   = 32'h0000_001c;
  localparam logic [31:0] start_addr       = 32'h0000_0020;
  localparam logic [31:0] stop_addr        = 32'h0000_0024;
  localparam logic [31:0] hash_sel_addr    = 32'h0000_0028;

  // Read side, core results
  localparam logic [31:0] status_addr      = 32'h0000_0030;
  localparam logic [31:0] nonce_addr       = 32'h0000_0034;
  localparam logic [31:0] heavyhash_addr   = 32'h0000_0038;

endpackage

// ==== rtl/ocl_axil_slave.sv ====
`timescale 1ns/1ps

module ocl_axil_slave
  import ocl_pkg::*;
(
  input  logic                  clk_main_a0,
  input  logic                  rst_main_n_sync,

  // AXI-Lite from the management bus
  input  logic                  awvalid,
  input  logic [ocl_addr_w-1:0] awaddr,
  input  logic                  wvalid,
  input  logic [ocl_data_w-1:0] wdata,
  input  logic [ocl_strb_w-1:0] wstrb,
  input  logic                  bready,
  input  logic                  arvalid,
  input  logic [ocl_addr_w-1:0] araddr,
  input  logic                  rready,

  // AXI-Lite back to the management bus
  output logic                  awready,
  output logic                  wready,
  output logic                  bvalid,
  output logic [1:0]            bresp,
  output logic                  arready,
  output logic                  rvalid,
  output logic [ocl_data_w-1:0] rdata,
  output logic [1:0]            rresp,

  // Write request to both register blocks
  output logic                  wr_en,
  output logic [ocl_addr_w-1:0] wr_addr,
  output logic [ocl_data_w-1:0] wr_data,

  // Read request to both register blocks
  output logic                  rd_req,
  output logic [ocl_addr_w-1:0] rd_addr,

  // Read results back from the blocks
  input  logic                  board_rd_hit,
  input  logic [ocl_data_w-1:0] board_rd_data,
  input  logic                  miner_rd_hit,
  input  logic [ocl_data_w-1:0] miner_rd_data
);

  // Write in flight, from aw handshake to b handshake
  logic                  wr_active;
  logic [ocl_addr_w-1:0] wr_addr_q;

  // Read address taken, results due this cycle
  logic                  rd_pend;
  logic [ocl_addr_w-1:0] rd_addr_q;

  // --------------------------------------------------
  // Write channel
  // --------------------------------------------------

  // New address only once the last response is gone
  assign awready = ~wr_active;

  // One data beat per write, blocked once the response is up
  assign wready = wr_active & ~bvalid & wvalid;

  // Registers are whole-word, wstrb is not decoded
  assign wr_en   = wready;
  assign wr_addr = wr_addr_q;
  assign wr_data = wdata;

  always_ff @(posedge clk_main_a0)
  begin
    if (!rst_main_n_sync)
    begin
      wr_active <= 1'b0;
    end
    else if (bvalid && bready)
    begin
      wr_active <= 1'b0;
    end
    else if (awvalid && awready)
    begin
      wr_active <= 1'b1;
    end
  end

  // Address capture on the aw handshake
  always_ff @(posedge clk_main_a0)
  begin
    if (awvalid && awready)
    begin
      wr_addr_q <= awaddr;
    end
  end

  // Response raised after the data beat, held until taken
  always_ff @(posedge clk_main_a0)
  begin
    if (!rst_main_n_sync)
    begin
      bvalid <= 1'b0;
    end
    else if (bvalid && bready)
    begin
      bvalid <= 1'b0;
    end
    else if (wready)
    begin
      bvalid <= 1'b1;
    end
  end

  assign bresp = ocl_resp_okay;

  // --------------------------------------------------
  // Read channel
  // --------------------------------------------------

  // One read at a time, including its response
  assign arready = ~rd_pend & ~rvalid;

  always_ff @(posedge clk_main_a0)
  begin
    if (!rst_main_n_sync)
    begin
      rd_pend <= 1'b0;
    end
    else
    begin
      rd_pend <= arvalid & arready;
    end
  end

  always_ff @(posedge clk_main_a0)
  begin
    if (arvalid && arready)
    begin
      rd_addr_q <= araddr;
    end
  end

  // Blocks see the request one cycle after the handshake
  assign rd_req  = rd_pend;
  assign rd_addr = rd_addr_q;

  always_ff @(posedge clk_main_a0)
  begin
    if (!rst_main_n_sync)
    begin
      rvalid <= 1'b0;
    end
    else if (rd_pend)
    begin
      rvalid <= 1'b1;
    end
    else if (rready)
    begin
      rvalid <= 1'b0;
    end
  end

  // Blocks own disjoint addresses, so the priority never matters
  always_ff @(posedge clk_main_a0)
  begin
    if (rd_pend)
    begin
      if (board_rd_hit)
      begin
        rdata <= board_rd_data;
      end
      else if (miner_rd_hit)
      begin
        rdata <= miner_rd_data;
      end
      else
      begin
        rdata <= unimpl_reg_value;
      end
    end
  end

  assign rresp = ocl_resp_okay;

endmodule

// ==== rtl/board_regs.sv ====
`timescale 1ns/1ps

module board_regs
  import ocl_pkg::*;
(
  input  logic                  clk_main_a0,
  input  logic                  rst_main_n_sync,

  // Write request from the slave
  input  logic                  wr_en,
  input  logic [ocl_addr_w-1:0] wr_addr,
  input  logic [ocl_data_w-1:0] wr_data,

  // Read request and answer
  input  logic                  rd_req,
  input  logic [ocl_addr_w-1:0] rd_addr,
  output logic                  rd_hit,
  output logic [ocl_data_w-1:0] rd_data,

  // Virtual switches in, virtual LEDs out
  input  logic [vled_w-1:0]     status_vdip,
  output logic [vled_w-1:0]     status_vled
);

  logic [ocl_data_w-1:0] hello_world_q;
  logic [ocl_data_w-1:0] hello_world_swapped;
  logic [vled_w-1:0]     vled_q;
  logic [vled_w-1:0]     vdip_q1;
  logic [vled_w-1:0]     vdip_q2;

  // --------------------------------------------------
  // Scratch register
  // --------------------------------------------------

  always_ff @(posedge clk_main_a0)
  begin
    if (!rst_main_n_sync)
    begin
      hello_world_q <= '0;
    end
    else if (wr_en && (wr_addr == hello_world_addr))
    begin
      hello_world_q <= wr_data;
    end
  end

  // Byte order reversed on readback
  assign hello_world_swapped = {hello_world_q[7:0], hello_world_q[15:8],
                                hello_world_q[23:16], hello_world_q[31:24]};

  // --------------------------------------------------
  // Virtual LEDs and DIP switches
  // --------------------------------------------------

  // LED shadow of the low half, two DIP sync stages, registered output
  always_ff @(posedge clk_main_a0)
  begin
    if (!rst_main_n_sync)
    begin
      vled_q      <= '0;
      vdip_q1     <= '0;
      vdip_q2     <= '0;
      status_vled <= '0;
    end
    else
    begin
      vled_q      <= hello_world_q[vled_w-1:0];
      vdip_q1     <= status_vdip;
      vdip_q2     <= vdip_q1;
      // Switch off masks the LED
      status_vled <= vled_q & vdip_q2;
    end
  end

  // Answer only in the request cycle
  assign rd_hit = rd_req & ((rd_addr == hello_world_addr) | (rd_addr == vled_addr));

  // LED shadow zero-extended to a full word
  assign rd_data = (rd_addr == hello_world_addr) ? hello_world_swapped :
                   {{(ocl_data_w - vled_w){1'b0}}, vled_q};

endmodule

// ==== rtl/miner_ctrl_regs.sv ====
`timescale 1ns/1ps

module miner_ctrl_regs
  import ocl_pkg::*;
  import miner_pkg::*;
(
  input  logic                  clk_main_a0,
  input  logic                  rst_main_n_sync,

  // Write request from the slave
  input  logic                  wr_en,
  input  logic [ocl_addr_w-1:0] wr_addr,
  input  logic [ocl_data_w-1:0] wr_data,

  // Read request and answer
  input  logic                  rd_req,
  input  logic [ocl_addr_w-1:0] rd_addr,
  output logic                  rd_hit,
  output logic [ocl_data_w-1:0] rd_data,

  // Results from the hashing core
  input  logic [status_w-1:0]   miner_status,
  input  logic [ocl_data_w-1:0] miner_nonce,
  input  logic [ocl_data_w-1:0] heavyhash,

  // Loads into the hashing core
  output logic                  block_header_we,
  output logic [ocl_data_w-1:0] block_header,
  output logic                  matrix_fifo_we,
  output logic [ocl_data_w-1:0] matrix_in,
  output logic                  target_we,
  output logic [ocl_data_w-1:0] target,
  output logic                  start,
  output logic                  stop,
  output logic [ocl_data_w-1:0] nonce_size,
  output logic [hash_sel_w-1:0] hash_select,
  output logic                  hash_re
);

  // Write address decode, valid only with wr_en
  logic hit_blockheader;
  logic hit_matrix;
  logic hit_target;

  assign hit_blockheader = wr_en & (wr_addr == blockheader_addr);
  assign hit_matrix      = wr_en & (wr_addr == matrix_addr);
  assign hit_target      = wr_en & (wr_addr == target_addr);

  // --------------------------------------------------
  // Load strobes
  // --------------------------------------------------

  // One cycle after the data beat, data zero when idle
  always_ff @(posedge clk_main_a0)
  begin
    if (!rst_main_n_sync)
    begin
      block_header_we <= 1'b0;
      block_header    <= '0;
      matrix_fifo_we  <= 1'b0;
      matrix_in       <= '0;
      target_we       <= 1'b0;
      target          <= '0;
      start           <= 1'b0;
      stop            <= 1'b0;
    end
    else
    begin
      block_header_we <= hit_blockheader;
      block_header    <= hit_blockheader ? wr_data : '0;
      matrix_fifo_we  <= hit_matrix;
      matrix_in       <= hit_matrix ? wr_data : '0;
      target_we       <= hit_target;
      target          <= hit_target ? wr_data : '0;
      // Commands carry no data
      start           <= wr_en & (wr_addr == start_addr);
      stop            <= wr_en & (wr_addr == stop_addr);
    end
  end

  // --------------------------------------------------
  // Held settings
  // --------------------------------------------------

  always_ff @(posedge clk_main_a0)
  begin
    if (!rst_main_n_sync)
    begin
      nonce_size  <= '0;
      hash_select <= '0;
    end
    else if (wr_en)
    begin
      if (wr_addr == noncesize_addr)
      begin
        nonce_size <= wr_data;
      end
      // Low bits pick one hash block
      if (wr_addr == hash_sel_addr)
      begin
        hash_select <= wr_data[hash_sel_w-1:0];
      end
    end
  end

  // --------------------------------------------------
  // Result readback
  // --------------------------------------------------

  assign rd_hit = rd_req & ((rd_addr == status_addr) | (rd_addr == nonce_addr) |
                            (rd_addr == heavyhash_addr));

  always_comb
  begin
    if (rd_addr == status_addr)
    begin
      rd_data = {{(ocl_data_w - status_w){1'b0}}, miner_status};
    end
    else if (rd_addr == nonce_addr)
    begin
      rd_data = miner_nonce;
    end
    else
    begin
      rd_data = heavyhash;
    end
  end

  // Core pops its hash on read, lines up with rvalid rising
  always_ff @(posedge clk_main_a0)
  begin
    if (!rst_main_n_sync)
    begin
      hash_re <= 1'b0;
    end
    else
    begin
      hash_re <= rd_req & (rd_addr == heavyhash_addr);
    end
  end

endmodule

// ==== rtl/cl_miner_shell.sv ====
`timescale 1ns/1ps

module cl_miner_shell
  import ocl_pkg::*;
  import miner_pkg::*;
(
  input  logic                  clk_main_a0,
  input  logic                  rst_main_n_sync,

  // Management AXI-Lite
  input  logic                  awvalid,
  input  logic [ocl_addr_w-1:0] awaddr,
  output logic                  awready,
  input  logic                  wvalid,
  input  logic [ocl_data_w-1:0] wdata,
  input  logic [ocl_strb_w-1:0] wstrb,
  output logic                  wready,
  output logic                  bvalid,
  output logic [1:0]            bresp,
  input  logic                  bready,
  input  logic                  arvalid,
  input  logic [ocl_addr_w-1:0] araddr,
  output logic                  arready,
  output logic                  rvalid,
  output logic [ocl_data_w-1:0] rdata,
  output logic [1:0]            rresp,
  input  logic                  rready,

  // Virtual switches and LEDs
  input  logic [vled_w-1:0]     status_vdip,
  output logic [vled_w-1:0]     status_vled,

  // Hashing core side
  input  logic [status_w-1:0]   miner_status,
  input  logic [ocl_data_w-1:0] miner_nonce,
  input  logic [ocl_data_w-1:0] heavyhash,
  output logic                  block_header_we,
  output logic [ocl_data_w-1:0] block_header,
  output logic                  matrix_fifo_we,
  output logic [ocl_data_w-1:0] matrix_in,
  output logic                  target_we,
  output logic [ocl_data_w-1:0] target,
  output logic                  start,
  output logic                  stop,
  output logic [ocl_data_w-1:0] nonce_size,
  output logic [hash_sel_w-1:0] hash_select,
  output logic                  hash_re
);

  // --------------------------------------------------
  // Internal register bus
  // --------------------------------------------------

  logic                  wr_en;
  logic [ocl_addr_w-1:0] wr_addr;
  logic [ocl_data_w-1:0] wr_data;
  logic                  rd_req;
  logic [ocl_addr_w-1:0] rd_addr;
  logic                  board_rd_hit;
  logic [ocl_data_w-1:0] board_rd_data;
  logic                  miner_rd_hit;
  logic [ocl_data_w-1:0] miner_rd_data;

  // Bus slave, single-beat only
  ocl_axil_slave i_ocl_axil_slave (
    .clk_main_a0     (clk_main_a0),
    .rst_main_n_sync (rst_main_n_sync),
    .awvalid         (awvalid),
    .awaddr          (awaddr),
    .wvalid          (wvalid),
    .wdata           (wdata),
    .wstrb           (wstrb),
    .bready          (bready),
    .arvalid         (arvalid),
    .araddr          (araddr),
    .rready          (rready),
    .awready         (awready),
    .wready          (wready),
    .bvalid          (bvalid),
    .bresp           (bresp),
    .arready         (arready),
    .rvalid          (rvalid),
    .rdata           (rdata),
    .rresp           (rresp),
    .wr_en           (wr_en),
    .wr_addr         (wr_addr),
    .wr_data         (wr_data),
    .rd_req          (rd_req),
    .rd_addr         (rd_addr),
    .board_rd_hit    (board_rd_hit),
    .board_rd_data   (board_rd_data),
    .miner_rd_hit    (miner_rd_hit),
    .miner_rd_data   (miner_rd_data)
  );

  // Scratch and LED registers
  board_regs i_board_regs (
    .clk_main_a0     (clk_main_a0),
    .rst_main_n_sync (rst_main_n_sync),
    .wr_en           (wr_en),
    .wr_addr         (wr_addr),
    .wr_data         (wr_data),
    .rd_req          (rd_req),
    .rd_addr         (rd_addr),
    .rd_hit          (board_rd_hit),
    .rd_data         (board_rd_data),
    .status_vdip     (status_vdip),
    .status_vled     (status_vled)
  );

  // Hashing core control
  miner_ctrl_regs i_miner_ctrl_regs (
    .clk_main_a0     (clk_main_a0),
    .rst_main_n_sync (rst_main_n_sync),
    .wr_en           (wr_en),
    .wr_addr         (wr_addr),
    .wr_data         (wr_data),
    .rd_req          (rd_req),
    .rd_addr         (rd_addr),
    .rd_hit          (miner_rd_hit),
    .rd_data         (miner_rd_data),
    .miner_status    (miner_status),
    .miner_nonce     (miner_nonce),
    .heavyhash       (heavyhash),
    .block_header_we (block_header_we),
    .block_header    (block_header),
    .matrix_fifo_we  (matrix_fifo_we),
    .matrix_in       (matrix_in),
    .target_we       (target_we),
    .target          (target),
    .start           (start),
    .stop            (stop),
    .nonce_size      (nonce_size),
    .hash_select     (hash_select),
    .hash_re         (hash_re)
  );

endmodule

// ==== tests/cl_miner_shell_asserts.sv ====
`timescale 1ns/1ps

module cl_miner_shell_asserts
  import ocl_pkg::*;
(
  input logic                  clk_main_a0,
  input logic                  rst_main_n_sync,

  // Response channels
  input logic                  bvalid,
  input logic                  bready,
  input logic [1:0]            bresp,
  input logic                  rvalid,
  input logic                  rready,
  input logic [1:0]            rresp,
  input logic [ocl_data_w-1:0] rdata,

  // Miner strobes
  input logic                  block_header_we,
  input logic                  matrix_fifo_we,
  input logic                  target_we,
  input logic                  start,
  input logic                  stop,
  input logic                  hash_re
);

  // --------------------------------------------------
  // Response hold rules
  // --------------------------------------------------

  // Valid stays up until the manager takes it
  assert property (@(posedge clk_main_a0) disable iff (!rst_main_n_sync)
    (bvalid && !bready) |=> bvalid)
  else $error("bvalid dropped before bready was seen");

  assert property (@(posedge clk_main_a0) disable iff (!rst_main_n_sync)
    (rvalid && !rready) |=> rvalid)
  else $error("rvalid dropped before rready was seen");

  // Read data frozen during a stall
  assert property (@(posedge clk_main_a0) disable iff (!rst_main_n_sync)
    (rvalid && !rready) |=> $stable(rdata))
  else $error("rdata changed while rvalid waited for rready");

  // Only OKAY on either channel
  assert property (@(posedge clk_main_a0) disable iff (!rst_main_n_sync)
    (bresp == ocl_resp_okay) && (rresp == ocl_resp_okay))
  else $error("response code other than OKAY");

  // --------------------------------------------------
  // Single-cycle strobes
  // --------------------------------------------------

  assert property (@(posedge clk_main_a0) disable iff (!rst_main_n_sync)
    block_header_we |=> !block_header_we)
  else $error("block_header_we high two cycles in a row");

  assert property (@(posedge clk_main_a0) disable iff (!rst_main_n_sync)
    matrix_fifo_we |=> !matrix_fifo_we)
  else $error("matrix_fifo_we high two cycles in a row");

  assert property (@(posedge clk_main_a0) disable iff (!rst_main_n_sync)
    target_we |=> !target_we)
  else $error("target_we high two cycles in a row");

  assert property (@(posedge clk_main_a0) disable iff (!rst_main_n_sync)
    start |=> !start)
  else $error("start high two cycles in a row");

  assert property (@(posedge clk_main_a0) disable iff (!rst_main_n_sync)
    stop |=> !stop)
  else $error("stop high two cycles in a row");

  assert property (@(posedge clk_main_a0) disable iff (!rst_main_n_sync)
    hash_re |=> !hash_re)
  else $error("hash_re high two cycles in a row");

endmodule

// ==== tests/tb_cl_miner_shell.sv ====
`timescale 1ns/1ps

module tb_cl_miner_shell
  import ocl_pkg::*;
  import miner_pkg::*;
();

  // Handshake wait bound in cycles
  localparam int unsigned wait_limit = 64;

  logic                  clk_main_a0;
  logic                  rst_main_n_sync;
  logic                  awvalid;
  logic [ocl_addr_w-1:0] awaddr;
  logic                  awready;
  logic                  wvalid;
  logic [ocl_data_w-1:0] wdata;
  logic [ocl_strb_w-1:0] wstrb;
  logic                  wready;
  logic                  bvalid;
  logic [1:0]            bresp;
  logic                  bready;
  logic                  arvalid;
  logic [ocl_addr_w-1:0] araddr;
  logic                  arready;
  logic                  rvalid;
  logic [ocl_data_w-1:0] rdata;
  logic [1:0]            rresp;
  logic                  rready;
  logic [vled_w-1:0]     status_vdip;
  logic [vled_w-1:0]     status_vled;
  logic [status_w-1:0]   miner_status;
  logic [ocl_data_w-1:0] miner_nonce;
  logic [ocl_data_w-1:0] heavyhash;
  logic                  block_header_we;
  logic [ocl_data_w-1:0] block_header;
  logic                  matrix_fifo_we;
  logic [ocl_data_w-1:0] matrix_in;
  logic                  target_we;
  logic [ocl_data_w-1:0] target;
  logic                  start;
  logic                  stop;
  logic [ocl_data_w-1:0] nonce_size;
  logic [hash_sel_w-1:0] hash_select;
  logic                  hash_re;

  cl_miner_shell i_cl_miner_shell (.*);

  // Protocol checker on the DUT top
  bind cl_miner_shell cl_miner_shell_asserts i_cl_miner_shell_asserts (
    .clk_main_a0     (clk_main_a0),
    .rst_main_n_sync (rst_main_n_sync),
    .bvalid          (bvalid),
    .bready          (bready),
    .bresp           (bresp),
    .rvalid          (rvalid),
    .rready          (rready),
    .rresp           (rresp),
    .rdata           (rdata),
    .block_header_we (block_header_we),
    .matrix_fifo_we  (matrix_fifo_we),
    .target_we       (target_we),
    .start           (start),
    .stop            (stop),
    .hash_re         (hash_re)
  );

  always #5 clk_main_a0 = ~clk_main_a0;

  // --------------------------------------------------
  // Failure reporting and checks
  // --------------------------------------------------

  task automatic fail_run();
    $display("test failed");
    $fatal(1);
  endtask

  task automatic value_error(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    $display("Error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
    fail_run();
  endtask

  task automatic timeout_error(input string what);
    $display("Timeout at %0t ns: %s", $time, what);
    fail_run();
  endtask

  task automatic expect_word(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    assert (got === exp)
    else value_error(name, got, exp);
  endtask

  task automatic expect_bit(input string name, input logic got, input logic exp);
    assert (got === exp)
    else value_error(name, {31'd0, got}, {31'd0, exp});
  endtask

  // Strobe cycle right after the data beat
  task automatic check_strobes(input logic [31:0] addr, input logic [31:0] data);
    logic hit_bh;
    logic hit_mx;
    logic hit_tg;
    hit_bh = (addr == blockheader_addr);
    hit_mx = (addr == matrix_addr);
    hit_tg = (addr == target_addr);
    expect_bit("block_header_we", block_header_we, hit_bh);
    expect_word("block_header", block_header, hit_bh ? data : 32'd0);
    expect_bit("matrix_fifo_we", matrix_fifo_we, hit_mx);
    expect_word("matrix_in", matrix_in, hit_mx ? data : 32'd0);
    expect_bit("target_we", target_we, hit_tg);
    expect_word("target", target, hit_tg ? data : 32'd0);
    expect_bit("start", start, addr == start_addr);
    expect_bit("stop", stop, addr == stop_addr);
  endtask

  // --------------------------------------------------
  // Bus tasks entered and left on a falling edge
  // --------------------------------------------------

  task automatic bus_write(input logic [31:0] addr, input logic [31:0] data,
                           input int unsigned b_stall);
    int unsigned n;
    awvalid = 1'b1;
    awaddr  = addr;
    wvalid  = 1'b1;
    wdata   = data;
    wstrb   = 4'hf;
    n = 0;
    while (!awready)
    begin
      @(negedge clk_main_a0);
      n++;
      if (n > wait_limit)
        timeout_error("awready stayed low");
    end
    // Address taken on the edge just passed
    @(negedge clk_main_a0);
    awvalid = 1'b0;
    n = 0;
    while (!wready)
    begin
      @(negedge clk_main_a0);
      n++;
      if (n > wait_limit)
        timeout_error("wready never rose");
    end
    @(negedge clk_main_a0);
    wvalid = 1'b0;
    check_strobes(addr, data);
    // Manager stalls the response
    repeat (b_stall)
    begin
      expect_bit("bvalid", bvalid, 1'b1);
      expect_bit("awready", awready, 1'b0);
      @(negedge clk_main_a0);
    end
    n = 0;
    while (!bvalid)
    begin
      @(negedge clk_main_a0);
      n++;
      if (n > wait_limit)
        timeout_error("bvalid never rose");
    end
    bready = 1'b1;
    @(negedge clk_main_a0);
    bready = 1'b0;
    expect_bit("awready", awready, 1'b1);
  endtask

  task automatic bus_read(input logic [31:0] addr, input int unsigned r_stall,
                          output logic [31:0] data);
    int unsigned n;
    arvalid = 1'b1;
    araddr  = addr;
    n = 0;
    while (!arready)
    begin
      @(negedge clk_main_a0);
      n++;
      if (n > wait_limit)
        timeout_error("arready stayed low");
    end
    @(negedge clk_main_a0);
    arvalid = 1'b0;
    expect_bit("hash_re", hash_re, 1'b0);
    n = 0;
    while (!rvalid)
    begin
      @(negedge clk_main_a0);
      n++;
      if (n > wait_limit)
        timeout_error("rvalid never rose");
    end
    // Hash pop lines up with the first rvalid cycle
    expect_bit("hash_re", hash_re, addr == heavyhash_addr);
    data = rdata;
    repeat (r_stall)
    begin
      expect_bit("rvalid", rvalid, 1'b1);
      expect_bit("arready", arready, 1'b0);
      @(negedge clk_main_a0);
    end
    rready = 1'b1;
    @(negedge clk_main_a0);
    rready = 1'b0;
    expect_bit("rvalid", rvalid, 1'b0);
    expect_bit("arready", arready, 1'b1);
  endtask

  // --------------------------------------------------
  // Cycle relations on the top level
  // --------------------------------------------------

  assert property (@(posedge clk_main_a0) disable iff (!rst_main_n_sync)
    wready |=> bvalid)
  else value_error("bvalid", {31'd0, bvalid}, 32'd1);

  assert property (@(posedge clk_main_a0) disable iff (!rst_main_n_sync)
    bvalid |-> !awready)
  else value_error("awready", {31'd0, awready}, 32'd0);

  assert property (@(posedge clk_main_a0) disable iff (!rst_main_n_sync)
    (arvalid && arready) |-> ##2 rvalid)
  else value_error("rvalid", {31'd0, rvalid}, 32'd1);

  assert property (@(posedge clk_main_a0) disable iff (!rst_main_n_sync)
    hash_re |-> rvalid)
  else value_error("rvalid", {31'd0, rvalid}, 32'd1);

  initial
  begin
    logic [31:0] word;
    logic [31:0] got;
    logic [31:0] ns_word;
    logic [31:0] hs_word;
    logic [31:0] hello_model;
    logic [15:0] dip_model;
    logic [15:0] dip_next;
    void'($urandom(32'hcc27_0f24));
    clk_main_a0     = 1'b0;
    rst_main_n_sync = 1'b0;
    awvalid         = 1'b0;
    awaddr          = '0;
    wvalid          = 1'b0;
    wdata           = '0;
    wstrb           = '0;
    bready          = 1'b0;
    arvalid         = 1'b0;
    araddr          = '0;
    rready          = 1'b0;
    status_vdip     = '0;
    miner_status    = '0;
    miner_nonce     = '0;
    heavyhash       = '0;
    hello_model     = '0;
    dip_model       = '0;
    repeat (2) @(posedge clk_main_a0);
    @(negedge clk_main_a0);
    // Reset values
    expect_bit("awready", awready, 1'b1);
    expect_bit("arready", arready, 1'b1);
    expect_bit("wready", wready, 1'b0);
    expect_bit("bvalid", bvalid, 1'b0);
    expect_bit("rvalid", rvalid, 1'b0);
    expect_bit("hash_re", hash_re, 1'b0);
    expect_word("status_vled", {16'd0, status_vled}, 32'd0);
    check_strobes(32'hffff_ffff, 32'd0);
    rst_main_n_sync = 1'b1;

    // Scratch byte swap, LED readback, unmapped read
    word = $urandom();
    bus_write(hello_world_addr, word, $urandom_range(0, 4));
    hello_model = word;
    bus_read(hello_world_addr, $urandom_range(0, 4), got);
    expect_word("rdata", got, {word[7:0], word[15:8], word[23:16], word[31:24]});
    bus_read(vled_addr, $urandom_range(0, 4), got);
    expect_word("rdata", got, {16'd0, word[15:0]});
    bus_write(32'h0000_0100, $urandom(), $urandom_range(0, 4));
    bus_read(32'h0000_0100, $urandom_range(0, 4), got);
    expect_word("rdata", got, 32'hdead_beef);

    // LED output two edges after the write, DIP three edges after a change
    dip_model   = 16'($urandom());
    status_vdip = dip_model;
    repeat (3) @(negedge clk_main_a0);
    expect_word("status_vled", {16'd0, status_vled}, {16'd0, hello_model[15:0] & dip_model});
    word = $urandom();
    bus_write(hello_world_addr, word, 0);
    expect_word("status_vled", {16'd0, status_vled}, {16'd0, hello_model[15:0] & dip_model});
    @(negedge clk_main_a0);
    expect_word("status_vled", {16'd0, status_vled}, {16'd0, word[15:0] & dip_model});
    hello_model = word;
    dip_next    = 16'($urandom());
    status_vdip = dip_next;
    repeat (2)
    begin
      @(negedge clk_main_a0);
      expect_word("status_vled", {16'd0, status_vled}, {16'd0, word[15:0] & dip_model});
    end
    @(negedge clk_main_a0);
    expect_word("status_vled", {16'd0, status_vled}, {16'd0, word[15:0] & dip_next});
    dip_model = dip_next;

    // Load strobes and commands
    bus_write(blockheader_addr, $urandom(), $urandom_range(0, 4));
    bus_write(matrix_addr, $urandom(), $urandom_range(0, 4));
    bus_write(target_addr, $urandom(), $urandom_range(0, 4));
    bus_write(start_addr, $urandom(), $urandom_range(0, 4));
    bus_write(stop_addr, $urandom(), $urandom_range(0, 4));

    // Held settings survive other writes
    ns_word = $urandom();
    hs_word = $urandom();
    bus_write(noncesize_addr, ns_word, $urandom_range(0, 4));
    bus_write(hash_sel_addr, hs_word, $urandom_range(0, 4));
    bus_write(target_addr, $urandom(), $urandom_range(0, 4));
    bus_write(start_addr, $urandom(), $urandom_range(0, 4));
    expect_word("nonce_size", nonce_size, ns_word);
    expect_word("hash_select", {29'd0, hash_select}, {29'd0, hs_word[2:0]});

    // Core results on reads
    miner_status = 2'($urandom());
    miner_nonce  = $urandom();
    heavyhash    = $urandom();
    bus_read(status_addr, $urandom_range(0, 4), got);
    expect_word("rdata", got, {30'd0, miner_status});
    bus_read(nonce_addr, $urandom_range(0, 4), got);
    expect_word("rdata", got, miner_nonce);
    bus_read(heavyhash_addr, $urandom_range(0, 4), got);
    expect_word("rdata", got, heavyhash);

    // Long response stalls on both channels
    repeat (4)
    begin
      word = $urandom();
      bus_write(hello_world_addr, word, $urandom_range(1, 8));
      bus_read(hello_world_addr, $urandom_range(1, 8), got);
      expect_word("rdata", got, {word[7:0], word[15:8], word[23:16], word[31:24]});
    end

    $display("test passed");
    $finish;
  end

endmodule

// ==== sources.f ====
rtl/ocl_pkg.sv
rtl/miner_pkg.sv
rtl/ocl_axil_slave.sv
rtl/board_regs.sv
rtl/miner_ctrl_regs.sv
rtl/cl_miner_shell.sv
tests/cl_miner_shell_asserts.sv
tests/tb_cl_miner_shell.sv

// ==== Makefile ====
# Verilator build and run of the register front end testbench

obj_dir/Vtb_cl_miner_shell: sources.f rtl/*.sv tests/*.sv
	verilator --binary --timing --assert -j 0 --top-module tb_cl_miner_shell -f sources.f

.PHONY: run clean

# Simulator exit code is ignored, the log decides
run: obj_dir/Vtb_cl_miner_shell
	-./obj_dir/Vtb_cl_miner_shell | tee sim.log
	@if grep -q "test failed" sim.log; then exit 1; fi
	@grep -q "test passed" sim.log

clean:
	rm -rf obj_dir sim.log
